// ==== Makefile ====
SIM       := verilator
SIM_FLAGS := --binary --timing --assert -Wno-fatal
TOP       := tb_rta
FILELIST  := filelist.f
OBJ_DIR   := obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   list these targets"

test:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf $(OBJ_DIR)

// ==== design/mem_controller.sv ====
/* Scene loader FSM with MMIO registers. RD_ADDR and RD_SIZE writes are dropped
   while loading, and store pointers carry over from one load to the next */
`timescale 1ns/100ps
`include "rta_defs.svh"

module mem_controller (
  input  logic                               clk,
  input  logic                               rst,
  input  rta_bus_pkg::mmio_req_t             mmio_req,
  output rta_bus_pkg::mmio_rsp_t             mmio_rsp,
  output rta_bus_pkg::dma_rd_req_t           dma_req,
  input  rta_bus_pkg::dma_rd_rsp_t           dma_rsp,
  output logic [31:0]                        word_data,
  output logic                               inst_we,
  output logic                               const_we,
  output logic [$clog2(`RTA_INST_DEPTH)-1:0] word_addr,
  output logic [`RTA_LINE_W-1:0]             line_data,
  output logic                               tri_we,
  output logic                               load_done
);
  import rta_bus_pkg::*;
  import rta_scene_pkg::*;

  localparam int WA_W      = $clog2(`RTA_INST_DEPTH);
  localparam int CA_W      = $clog2(`RTA_CONST_DEPTH);
  localparam int TRI_LINES = 3 * `RTA_TRI_NUM;

  typedef enum logic [2:0] {IDLE, HEADER, WORDS, TRI, DONE} state_e;

  state_e                       state;
  logic [31:0]                  rd_addr_r;
  logic [31:0]                  rd_size_r;
  logic                         rd_go_r;
  logic                         error_r;
  logic                         rsp_valid_r;
  logic [31:0]                  rsp_data_r;
  // Lines still owed by the DMA for this load
  logic [31:0]                  lines_left;
  // Payload lines left in the current segment
  logic [15:0]                  seg_left;
  seg_kind_e                    seg_kind;
  logic [1:0]                   word_idx;
  // One extra bit so a full store is visible
  logic [WA_W:0]                inst_ptr;
  logic [CA_W:0]                const_ptr;
  logic [$clog2(TRI_LINES):0]   tri_lines;
  seg_hdr_t                     hdr;
  logic                         avail;
  logic                         dry;
  logic                         full;
  logic                         take;
  logic                         loading;
  logic                         go_wr;

  // ========================================
  // Stream decode
  // ========================================

  assign hdr     = seg_hdr_t'(dma_rsp.rd_data);
  // Stale lines from an earlier load are skipped during the go pulse
  assign avail   = !dma_rsp.empty && !rd_go_r;
  assign dry     = lines_left == 0 || (dma_rsp.rd_done && !rd_go_r);
  assign loading = state inside {HEADER, WORDS, TRI};
  assign go_wr   = mmio_req.wr_en && mmio_reg_e'(mmio_req.addr) == GO && !loading;

  // Overflow check for the store the segment targets
  always_comb begin
    if (state == TRI)
      full = tri_lines == TRI_LINES;
    else if (seg_kind == SEG_INST)
      full = inst_ptr == `RTA_INST_DEPTH;
    else
      full = const_ptr == `RTA_CONST_DEPTH;
  end

  // Strobes, pop only on the last word of a line
  always_comb begin
    take     = 1'b0;
    inst_we  = 1'b0;
    const_we = 1'b0;
    tri_we   = 1'b0;
    case (state)
      HEADER: take = avail && !dry;
      WORDS: begin
        if (avail && lines_left != 0 && !full) begin
          inst_we  = seg_kind == SEG_INST;
          const_we = seg_kind == SEG_CONST;
          take     = word_idx == 2'd3;
        end
      end
      TRI: begin
        tri_we = avail && lines_left != 0 && !full;
        take   = tri_we;
      end
      default: ;
    endcase
  end

  // ========================================
  // Registers and FSM
  // ========================================

  always_ff @(posedge clk) begin
    if (rst) begin
      state       <= IDLE;
      rd_addr_r   <= '0;
      rd_size_r   <= '0;
      rd_go_r     <= 1'b0;
      error_r     <= 1'b0;
      rsp_valid_r <= 1'b0;
      lines_left  <= '0;
      seg_left    <= '0;
      seg_kind    <= SEG_INST;
      word_idx    <= '0;
      inst_ptr    <= '0;
      const_ptr   <= '0;
      tri_lines   <= '0;
    end else begin
      rd_go_r     <= go_wr;
      rsp_valid_r <= mmio_req.rd_en;
      if (mmio_req.wr_en && !loading) begin
        case (mmio_reg_e'(mmio_req.addr))
          RD_ADDR: rd_addr_r <= mmio_req.data;
          RD_SIZE: rd_size_r <= mmio_req.data;
          default: ;
        endcase
      end
      if (take)
        lines_left <= lines_left - 1'b1;
      if (inst_we)
        inst_ptr <= inst_ptr + 1'b1;
      if (const_we)
        const_ptr <= const_ptr + 1'b1;
      if (inst_we || const_we)
        word_idx <= word_idx + 2'd1;
      if (tri_we)
        tri_lines <= tri_lines + 1'b1;
      case (state)
        IDLE, DONE: begin
          if (go_wr) begin
            state      <= HEADER;
            error_r    <= 1'b0;
            lines_left <= rd_size_r;
          end
        end
        HEADER: begin
          if (dry) begin
            state <= DONE;
          end else if (take) begin
            seg_kind <= hdr.kind;
            seg_left <= hdr.line_cnt;
            word_idx <= '0;
            if (hdr.kind_hi != '0) begin
              error_r <= 1'b1;
              state   <= DONE;
            end else if (hdr.kind == SEG_END) begin
              state <= DONE;
            end else if (hdr.line_cnt != '0) begin
              state <= (hdr.kind == SEG_TRI) ? TRI : WORDS;
            end
          end
        end
        WORDS, TRI: begin
          if (lines_left == 0) begin
            state <= DONE;
          end else if (avail && full) begin
            error_r <= 1'b1;
            state   <= DONE;
          end else if (take) begin
            seg_left <= seg_left - 1'b1;
            if (seg_left == 16'd1)
              state <= HEADER;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // MMIO read data, answered next cycle
  always_ff @(posedge clk) begin
    if (mmio_req.rd_en) begin
      case (mmio_reg_e'(mmio_req.addr))
        RD_ADDR: rsp_data_r <= rd_addr_r;
        RD_SIZE: rsp_data_r <= rd_size_r;
        STATUS:  rsp_data_r <= {29'd0, error_r, state == DONE, loading};
        default: rsp_data_r <= '0;
      endcase
    end
  end

  assign mmio_rsp  = '{valid: rsp_valid_r, data: rsp_data_r};
  assign dma_req   = '{rd_addr: rd_addr_r, rd_size: rd_size_r, rd_go: rd_go_r, rd_en: take};
  // Low word first
  assign word_data = dma_rsp.rd_data[word_idx*32 +: 32];
  assign word_addr = (seg_kind == SEG_INST) ? inst_ptr[WA_W-1:0]
                                            : WA_W'(const_ptr[CA_W-1:0]);
  assign line_data = dma_rsp.rd_data;
  assign load_done = state == DONE;

  // Source is never popped while it reports empty
  a_no_pop_empty: assert property (@(posedge clk) disable iff (rst)
    dma_req.rd_en |-> !dma_rsp.empty);

  // At most one store written per cycle
  a_one_we: assert property (@(posedge clk) disable iff (rst)
    $onehot0({inst_we, const_we, tri_we}));

endmodule

// ==== design/mem_simple.sv ====
/* Word store with a registered read port. A read returns the old word when a
   write hits the same address on the same edge */
`timescale 1ns/100ps
`include "rta_defs.svh"

module mem_simple #(
  parameter int DEPTH = 256
) (
  input  logic                               clk,
  input  logic                               rst,
  input  logic                               we,
  input  logic [$clog2(`RTA_INST_DEPTH)-1:0] waddr,
  input  logic [31:0]                        wdata,
  input  rta_scene_pkg::word_rd_req_t        rd_req,
  output logic [31:0]                        rd_data
);

  localparam int AW = $clog2(DEPTH);

  logic [31:0] mem [DEPTH];

  // Loader write port
  always_ff @(posedge clk) begin
    if (we)
      mem[waddr[AW-1:0]] <= wdata;
  end

  // Core read port, upper address bits ignored
  always_ff @(posedge clk) begin
    if (rst)
      rd_data <= '0;
    else if (rd_req.re)
      rd_data <= mem[rd_req.addr[AW-1:0]];
  end

  // Loader keeps its pointer inside this store
  a_waddr_range: assert property (@(posedge clk) disable iff (rst)
    we |-> waddr < DEPTH);

endmodule

// ==== design/mem_triangle.sv ====
/* Triangle store fed three lines per entry in order. Partial triangles are
   held in staging and are not readable until the third line lands */
`timescale 1ns/100ps
`include "rta_defs.svh"

module mem_triangle (
  input  logic                       clk,
  input  logic                       rst,
  input  logic [`RTA_LINE_W-1:0]     line_data,
  input  logic                       we,
  input  rta_scene_pkg::tri_rd_req_t rd_req,
  output rta_scene_pkg::tri_rd_rsp_t rd_rsp
);
  import rta_scene_pkg::*;

  localparam int ID_W = $clog2(`RTA_TRI_NUM);

  triangle_t         mem [`RTA_TRI_NUM];
  // Which vertex the next line fills
  logic [1:0]        phase;
  logic [VERT_W-1:0] vert0_r;
  logic [VERT_W-1:0] vert1_r;
  // Completed triangles
  logic [ID_W:0]     count;
  logic              commit;
  triangle_t         staged;
  logic              rdy_r;
  logic              not_valid_r;
  triangle_t         tri_r;

  assign commit = we && phase == 2'd2;
  // Third line gives vertex2 and the sid bit
  assign staged = '{vertex0: vert0_r, vertex1: vert1_r,
                    vertex2: line_data[VERT_W-1:0], sid: line_data[VERT_W]};

  // ========================================
  // Line assembly
  // ========================================

  always_ff @(posedge clk) begin
    if (rst) begin
      phase <= '0;
      count <= '0;
    end else if (we) begin
      phase <= commit ? 2'd0 : phase + 2'd1;
      if (commit)
        count <= count + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (we && phase == 2'd0)
      vert0_r <= line_data[VERT_W-1:0];
    if (we && phase == 2'd1)
      vert1_r <= line_data[VERT_W-1:0];
    if (commit)
      mem[count[ID_W-1:0]] <= staged;
  end

  // ========================================
  // Read port
  // ========================================

  always_ff @(posedge clk) begin
    if (rst)
      rdy_r <= 1'b0;
    else
      rdy_r <= rd_req.re;
  end

  // Ids at or past the count are flagged
  always_ff @(posedge clk) begin
    if (rd_req.re) begin
      not_valid_r <= {1'b0, rd_req.id} >= count;
      tri_r       <= mem[rd_req.id];
    end
  end

  assign rd_rsp = '{rdy: rdy_r, not_valid: not_valid_r, triangle: tri_r};

  // Loader stops before the store is full
  a_no_overflow: assert property (@(posedge clk) disable iff (rst)
    commit |-> count < `RTA_TRI_NUM);

endmodule

// ==== design/rta.sv ====
/* Scene loading subsystem top. One read port per memory, and the loader owns
   every write path */
`timescale 1ns/100ps
`include "rta_defs.svh"

module rta (
  input  logic                       clk,
  input  logic                       rst,
  input  rta_bus_pkg::mmio_req_t     mmio_req,
  output rta_bus_pkg::mmio_rsp_t     mmio_rsp,
  output rta_bus_pkg::dma_rd_req_t   dma_req,
  input  rta_bus_pkg::dma_rd_rsp_t   dma_rsp,
  input  rta_scene_pkg::word_rd_req_t inst_rd,
  output logic [31:0]                inst_data,
  input  rta_scene_pkg::word_rd_req_t const_rd,
  output logic [31:0]                const_data,
  input  rta_scene_pkg::tri_rd_req_t tri_rd,
  output rta_scene_pkg::tri_rd_rsp_t tri_rsp,
  output logic                       load_done
);

  // Loader to memories
  logic [31:0]                        word_data;
  logic                               inst_we;
  logic                               const_we;
  logic [$clog2(`RTA_INST_DEPTH)-1:0] word_addr;
  logic [`RTA_LINE_W-1:0]             line_data;
  logic                               tri_we;

  mem_controller memory_controller (
    .clk       (clk),
    .rst       (rst),
    .mmio_req  (mmio_req),
    .mmio_rsp  (mmio_rsp),
    .dma_req   (dma_req),
    .dma_rsp   (dma_rsp),
    .word_data (word_data),
    .inst_we   (inst_we),
    .const_we  (const_we),
    .word_addr (word_addr),
    .line_data (line_data),
    .tri_we    (tri_we),
    .load_done (load_done)
  );

  mem_simple #(.DEPTH(`RTA_INST_DEPTH)) memory_instruction (
    .clk     (clk),
    .rst     (rst),
    .we      (inst_we),
    .waddr   (word_addr),
    .wdata   (word_data),
    .rd_req  (inst_rd),
    .rd_data (inst_data)
  );

  mem_simple #(.DEPTH(`RTA_CONST_DEPTH)) memory_constant (
    .clk     (clk),
    .rst     (rst),
    .we      (const_we),
    .waddr   (word_addr),
    .wdata   (word_data),
    .rd_req  (const_rd),
    .rd_data (const_data)
  );

  mem_triangle memory_triangle (
    .clk       (clk),
    .rst       (rst),
    .line_data (line_data),
    .we        (tri_we),
    .rd_req    (tri_rd),
    .rd_rsp    (tri_rsp)
  );

endmodule

// ==== design/rta_bus_pkg.sv ====
/* MMIO and DMA read channel types. MMIO reads are answered one cycle later,
   and the DMA source shows a line on rd_data whenever empty is low */
`include "rta_defs.svh"

package rta_bus_pkg;

  // ========================================
  // MMIO
  // ========================================

  // Register map, indexed by mmio addr
  typedef enum logic [`RTA_MMIO_ADDR_W-1:0] {
    RD_ADDR = 'h0,
    RD_SIZE = 'h1,
    GO      = 'h2,
    STATUS  = 'h3
  } mmio_reg_e;

  typedef struct packed {
    logic                        wr_en;
    logic                        rd_en;
    logic [`RTA_MMIO_ADDR_W-1:0] addr;
    logic [31:0]                 data;
  } mmio_req_t;

  // Single-cycle read response
  typedef struct packed {
    logic        valid;
    logic [31:0] data;
  } mmio_rsp_t;

  // ========================================
  // DMA read channel
  // ========================================

  typedef struct packed {
    logic [31:0] rd_addr;
    logic [31:0] rd_size;
    logic        rd_go;
    logic        rd_en;
  } dma_rd_req_t;

  // rd_done holds once rd_size lines are taken
  typedef struct packed {
    logic                   empty;
    logic [`RTA_LINE_W-1:0] rd_data;
    logic                   rd_done;
  } dma_rd_rsp_t;

endpackage

// ==== design/rta_defs.svh ====
/* Scene loader sizes. Memory depths must be powers of two, and the word bus
   address is sized by the instruction store, which must stay the deepest */
`ifndef RTA_DEFS_SVH
`define RTA_DEFS_SVH

// ========================================
// DMA stream
// ========================================

// One cache line per DMA beat
`define RTA_LINE_W 128

// Register index width on the MMIO bus
`define RTA_MMIO_ADDR_W 4

// ========================================
// Memory sizes
// ========================================

// Instruction store in 32-bit words
`define RTA_INST_DEPTH 256
// Constant store in 32-bit words
`define RTA_CONST_DEPTH 64
// Triangle entries, three lines each
`define RTA_TRI_NUM 64

`endif

// ==== design/rta_scene_pkg.sv ====
/* Scene image and memory port types. Header bits 15:2 must be zero, and any
   other value there counts as an undefined segment kind */
`include "rta_defs.svh"

package rta_scene_pkg;

  // Vertex width, low bits of a triangle line
  localparam int VERT_W = 96;

  // Segment kinds in header bits 1:0
  typedef enum logic [1:0] {
    SEG_INST  = 2'd0,
    SEG_CONST = 2'd1,
    SEG_TRI   = 2'd2,
    SEG_END   = 2'd3
  } seg_kind_e;

  // Header line layout
  typedef struct packed {
    logic [`RTA_LINE_W-33:0] pad;
    logic [15:0]             line_cnt;
    // Upper kind bits, nonzero is an undefined kind
    logic [13:0]             kind_hi;
    seg_kind_e               kind;
  } seg_hdr_t;

  typedef struct packed {
    logic [VERT_W-1:0] vertex0;
    logic [VERT_W-1:0] vertex1;
    logic [VERT_W-1:0] vertex2;
    logic              sid;
  } triangle_t;

  typedef struct packed {
    logic        re;
    logic [31:0] addr;
  } word_rd_req_t;

  typedef struct packed {
    logic                           re;
    logic [$clog2(`RTA_TRI_NUM)-1:0] id;
  } tri_rd_req_t;

  typedef struct packed {
    logic      rdy;
    logic      not_valid;
    triangle_t triangle;
  } tri_rd_rsp_t;

endpackage

// ==== filelist.f ====
+incdir+design
design/rta_bus_pkg.sv
design/rta_scene_pkg.sv
design/mem_simple.sv
design/mem_triangle.sv
design/mem_controller.sv
design/rta.sv
test/rta_checker.sv
test/tb_rta.sv

// ==== test/rta_checker.sv ====
/* Testbench checker. Expected stores are rebuilt from the lines the DUT pops,
   and store overflow is not modeled, so images must fit every store */
`timescale 1ns/100ps
`include "rta_defs.svh"

module rta_checker (
  input logic                        clk,
  input logic                        rst,
  input rta_bus_pkg::dma_rd_req_t    dma_req,
  input rta_bus_pkg::dma_rd_rsp_t    dma_rsp,
  input rta_scene_pkg::word_rd_req_t inst_rd,
  input logic [31:0]                 inst_data,
  input rta_scene_pkg::word_rd_req_t const_rd,
  input logic [31:0]                 const_data,
  input rta_scene_pkg::tri_rd_req_t  tri_rd,
  input rta_scene_pkg::tri_rd_rsp_t  tri_rsp
);
  import rta_scene_pkg::*;

  localparam int IA_W = $clog2(`RTA_INST_DEPTH);
  localparam int CA_W = $clog2(`RTA_CONST_DEPTH);
  localparam int ID_W = $clog2(`RTA_TRI_NUM);

  // Where the next popped line goes
  typedef enum logic [1:0] {M_HDR, M_WORDS, M_TRI, M_STOP} mode_e;

  int                errors = 0;
  int                checks = 0;
  int                inst_cnt = 0;
  int                const_cnt = 0;
  int                tri_cnt = 0;
  logic [31:0]       exp_inst [`RTA_INST_DEPTH];
  logic [31:0]       exp_const [`RTA_CONST_DEPTH];
  triangle_t         exp_tri [`RTA_TRI_NUM];
  mode_e             mode = M_HDR;
  logic              to_inst;
  int                seg_left;
  // Vertex slot, carried across segments and loads
  int                phase = 0;
  logic [VERT_W-1:0] v0;
  logic [VERT_W-1:0] v1;
  // Reads seen last cycle, answered this cycle
  logic              inst_pend = 1'b0;
  logic              const_pend = 1'b0;
  logic              tri_pend = 1'b0;
  logic [IA_W-1:0]   inst_pend_addr;
  logic [CA_W-1:0]   const_pend_addr;
  logic [ID_W-1:0]   tri_pend_id;

  task automatic compare(input string what, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic compare_tri(input int id, input triangle_t got, input triangle_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH at %0t: triangle %0d got %h expected %h", $time, id, got, exp);
    end
  endtask

  // ========================================
  // Stream model
  // ========================================

  task automatic absorb_line(input logic [`RTA_LINE_W-1:0] ln);
    case (mode)
      M_HDR: begin
        // Bits 15:2 set means an undefined kind, load stops there
        if (ln[15:2] != '0) begin
          mode = M_STOP;
        end else if (ln[1:0] == SEG_END) begin
          mode = M_STOP;
        end else if (ln[31:16] != '0) begin
          seg_left = int'(ln[31:16]);
          to_inst  = ln[1:0] == SEG_INST;
          if (ln[1:0] == SEG_TRI)
            mode = M_TRI;
          else
            mode = M_WORDS;
        end
      end
      M_WORDS: begin
        // Low word lands first
        for (int w = 0; w < 4; w++) begin
          if (to_inst) begin
            exp_inst[inst_cnt] = ln[w*32 +: 32];
            inst_cnt++;
          end else begin
            exp_const[const_cnt] = ln[w*32 +: 32];
            const_cnt++;
          end
        end
        seg_left--;
        if (seg_left == 0)
          mode = M_HDR;
      end
      M_TRI: begin
        if (phase == 0)
          v0 = ln[VERT_W-1:0];
        else if (phase == 1)
          v1 = ln[VERT_W-1:0];
        else begin
          // sid rides on bit 96 of the third line
          exp_tri[tri_cnt] = '{vertex0: v0, vertex1: v1,
                               vertex2: ln[VERT_W-1:0], sid: ln[VERT_W]};
          tri_cnt++;
        end
        phase = (phase + 1) % 3;
        seg_left--;
        if (seg_left == 0)
          mode = M_HDR;
      end
      default: ;
    endcase
  endtask

  // ========================================
  // Sampling and compares
  // ========================================

  // Negedge view, all DUT outputs settled
  always @(negedge clk) begin
    if (!rst) begin
      if (dma_req.rd_go)
        mode = M_HDR;
      if (dma_req.rd_en)
        absorb_line(dma_rsp.rd_data);
      if (inst_pend && inst_pend_addr < inst_cnt)
        compare("inst word", inst_data, exp_inst[inst_pend_addr]);
      if (const_pend && const_pend_addr < const_cnt)
        compare("const word", const_data, exp_const[const_pend_addr]);
      // rdy must echo last cycle's re
      compare("tri rdy", 32'(tri_rsp.rdy), 32'(tri_pend));
      if (tri_pend) begin
        compare("tri not_valid", 32'(tri_rsp.not_valid), 32'(tri_pend_id >= tri_cnt));
        if (tri_pend_id < tri_cnt)
          compare_tri(int'(tri_pend_id), tri_rsp.triangle, exp_tri[tri_pend_id]);
      end
      inst_pend       = inst_rd.re;
      inst_pend_addr  = inst_rd.addr[IA_W-1:0];
      const_pend      = const_rd.re;
      const_pend_addr = const_rd.addr[CA_W-1:0];
      tri_pend        = tri_rd.re;
      tri_pend_id     = tri_rd.id;
    end
  end

endmodule

// ==== test/tb_rta.sv ====
/* Scene loader testbench. Two loads from one LFSR-built image, the second
   ending on an undefined header; all totals stay inside every store */
`timescale 1ns/100ps
`include "rta_defs.svh"

module tb_rta;
  import rta_bus_pkg::*;
  import rta_scene_pkg::*;

  localparam int          IMG_LINES   = 512;
  localparam int          IMG_W       = $clog2(IMG_LINES);
  localparam int          ID_W        = $clog2(`RTA_TRI_NUM);
  localparam int          LOAD1_BASE  = 8;
  localparam int          LOAD2_BASE  = 128;
  localparam int          READ_BUDGET = 3000;
  localparam logic [15:0] SEED        = 16'd6601;

  logic         clk = 1'b0;
  logic         rst;
  mmio_req_t    mmio_req;
  mmio_rsp_t    mmio_rsp;
  dma_rd_req_t  dma_req;
  dma_rd_rsp_t  dma_rsp;
  word_rd_req_t inst_rd;
  logic [31:0]  inst_data;
  word_rd_req_t const_rd;
  logic [31:0]  const_data;
  tri_rd_req_t  tri_rd;
  tri_rd_rsp_t  tri_rsp;
  logic         load_done;

  logic [`RTA_LINE_W-1:0] image [IMG_LINES];
  logic [15:0]            lfsr;
  int                     img_ptr;
  int                     load1_size;
  int                     load2_size;
  // Store totals that the image asks for
  int                     inst_words = 0;
  int                     const_words = 0;
  int                     tri_total = 0;
  int                     load1_inst;
  int                     load1_const;
  int                     load1_tri;
  int                     cycles = 0;
  int                     limit = 0;
  int                     tests = 0;
  int                     failed = 0;
  int                     err_mark = 0;
  logic [31:0]            rdata;
  // DMA source state
  logic                   src_active = 1'b0;
  logic                   src_pop;
  logic                   src_go;
  logic [31:0]            src_base;
  logic [31:0]            src_size;
  logic [31:0]            src_taken;
  logic [IMG_W-1:0]       src_idx;
  logic [`RTA_LINE_W-1:0] stall_bits;
  int                     go_count = 0;

  rta dut (
    .clk        (clk),
    .rst        (rst),
    .mmio_req   (mmio_req),
    .mmio_rsp   (mmio_rsp),
    .dma_req    (dma_req),
    .dma_rsp    (dma_rsp),
    .inst_rd    (inst_rd),
    .inst_data  (inst_data),
    .const_rd   (const_rd),
    .const_data (const_data),
    .tri_rd     (tri_rd),
    .tri_rsp    (tri_rsp),
    .load_done  (load_done)
  );

  rta_checker chk (
    .clk        (clk),
    .rst        (rst),
    .dma_req    (dma_req),
    .dma_rsp    (dma_rsp),
    .inst_rd    (inst_rd),
    .inst_data  (inst_data),
    .const_rd   (const_rd),
    .const_data (const_data),
    .tri_rd     (tri_rd),
    .tri_rsp    (tri_rsp)
  );

  always #5 clk = ~clk;

  // Galois LFSR, one step per bit handed out
  function automatic logic [`RTA_LINE_W-1:0] rand_bits(input int n);
    logic [`RTA_LINE_W-1:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r[i] = lfsr[0];
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
    end
    return r;
  endfunction

  // Run limit scales with the image length
  always @(posedge clk) begin
    cycles = cycles + 1;
    if (limit != 0 && cycles >= limit) begin
      $display("timeout: run did not finish within %0d cycles", limit);
      $display("sim failed");
      $finish;
    end
  end

  // ========================================
  // DMA source model
  // ========================================

  always begin
    @(negedge clk);
    src_pop    = dma_req.rd_en;
    src_go     = dma_req.rd_go;
    stall_bits = rand_bits(2);
    if (src_go) begin
      src_base = dma_req.rd_addr;
      src_size = dma_req.rd_size;
    end
    @(posedge clk);
    #1;
    if (src_go) begin
      src_active = 1'b1;
      src_taken  = '0;
      go_count++;
    end else if (src_pop) begin
      src_taken = src_taken + 1;
    end
    // Roughly one stall cycle in four
    src_idx         = IMG_W'(src_base + src_taken);
    dma_rsp.rd_done = src_active && src_taken == src_size;
    dma_rsp.empty   = !src_active || src_taken >= src_size || (stall_bits[0] && stall_bits[1]);
    dma_rsp.rd_data = image[src_idx];
  end

  // ========================================
  // Image build
  // ========================================

  task automatic add_junk(input int n);
    for (int i = 0; i < n; i++) begin
      image[img_ptr] = rand_bits(`RTA_LINE_W);
      img_ptr++;
    end
  endtask

  task automatic add_segment(input seg_kind_e kind, input int n);
    logic [`RTA_LINE_W-1:0] pad;
    pad = rand_bits(96);
    image[img_ptr] = {pad[95:0], 16'(n), 14'd0, kind};
    img_ptr++;
    add_junk(n);
    case (kind)
      SEG_INST:  inst_words += 4 * n;
      SEG_CONST: const_words += 4 * n;
      SEG_TRI:   tri_total += n / 3;
      default: ;
    endcase
  endtask

  task automatic build_image();
    logic [`RTA_LINE_W-1:0] pad;
    for (int i = 0; i < IMG_LINES; i++)
      image[i] = {4{32'(i)}};
    img_ptr = LOAD1_BASE;
    add_segment(SEG_INST, 6);
    add_segment(SEG_CONST, 3);
    add_segment(SEG_TRI, 0);
    add_segment(SEG_INST, 5);
    add_segment(SEG_TRI, 9);
    add_segment(SEG_CONST, 2);
    add_segment(SEG_TRI, 6);
    add_segment(SEG_END, 0);
    // Lines past the end header, never taken
    add_junk(3);
    load1_size  = img_ptr - LOAD1_BASE;
    load1_inst  = inst_words;
    load1_const = const_words;
    load1_tri   = tri_total;
    img_ptr = LOAD2_BASE;
    add_segment(SEG_INST, 4);
    add_segment(SEG_TRI, 6);
    add_segment(SEG_CONST, 2);
    // Undefined kind, bit 4 of the header set
    pad = rand_bits(96);
    image[img_ptr] = {pad[95:0], 16'd2, 14'h0004, 2'd0};
    img_ptr++;
    add_junk(5);
    load2_size = img_ptr - LOAD2_BASE;
  endtask

  // ========================================
  // Bus drivers
  // ========================================

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic mmio_write(input mmio_reg_e sel, input logic [31:0] data);
    mmio_req = '{wr_en: 1'b1, rd_en: 1'b0, addr: sel, data: data};
    idle(1);
    mmio_req = '0;
    // Writes get no read response
    chk.compare("mmio valid after write", 32'(mmio_rsp.valid), 32'd0);
  endtask

  task automatic mmio_read(input mmio_reg_e sel, output logic [31:0] data);
    mmio_req = '{wr_en: 1'b0, rd_en: 1'b1, addr: sel, data: 32'd0};
    idle(1);
    mmio_req = '0;
    chk.compare("mmio valid", 32'(mmio_rsp.valid), 32'd1);
    data = mmio_rsp.data;
  endtask

  task automatic wait_done();
    while (!load_done)
      idle(1);
  endtask

  // Both word stores read together, junk in the upper address bits
  task automatic read_words(input int ni, input int nc);
    int                     n_max;
    logic [`RTA_LINE_W-1:0] upper;
    n_max = (ni > nc) ? ni : nc;
    for (int i = 0; i < n_max; i++) begin
      upper    = rand_bits(26);
      inst_rd  = '{re: i < ni, addr: {upper[23:0], 8'(i)}};
      const_rd = '{re: i < nc, addr: {upper[25:0], 6'(i)}};
      idle(1);
    end
    inst_rd  = '0;
    const_rd = '0;
    idle(2);
  endtask

  task automatic read_triangles(input int n);
    for (int i = 0; i < n; i++) begin
      tri_rd = '{re: 1'b1, id: ID_W'(i)};
      idle(1);
      tri_rd = '0;
      idle(1);
    end
    idle(2);
  endtask

  // One read per cycle, ids spread around the count
  task automatic stream_triangles(input int n);
    logic [`RTA_LINE_W-1:0] bits;
    for (int i = 0; i < n; i++) begin
      bits   = rand_bits(4);
      tri_rd = '{re: 1'b1, id: ID_W'(bits[3:0])};
      idle(1);
    end
    tri_rd = '0;
    idle(2);
  endtask

  task automatic finish_test(input string name);
    int errs;
    errs     = chk.errors - err_mark;
    err_mark = chk.errors;
    tests++;
    if (errs != 0)
      failed++;
    $display("test %s: %s, %0d errors", name, (errs == 0) ? "ok" : "FAILED", errs);
  endtask

  task automatic check_counts(input int ni, input int nc, input int nt);
    chk.compare("inst words loaded", 32'(chk.inst_cnt), 32'(ni));
    chk.compare("const words loaded", 32'(chk.const_cnt), 32'(nc));
    chk.compare("triangles loaded", 32'(chk.tri_cnt), 32'(nt));
  endtask

  // ========================================
  // Test sequence
  // ========================================

  initial begin
    rst      = 1'b1;
    mmio_req = '0;
    dma_rsp  = '{empty: 1'b1, rd_data: '0, rd_done: 1'b0};
    inst_rd  = '0;
    const_rd = '0;
    tri_rd   = '0;
    lfsr     = SEED;
    build_image();
    limit = (load1_size + load2_size) * 4 * 8 + READ_BUDGET;
    repeat (8) @(posedge clk);
    #1;
    rst = 1'b0;

    chk.compare("load_done after reset", 32'(load_done), 32'd0);
    mmio_write(RD_ADDR, 32'(LOAD1_BASE));
    mmio_write(RD_SIZE, 32'(load1_size));
    mmio_read(RD_ADDR, rdata);
    chk.compare("RD_ADDR", rdata, 32'(LOAD1_BASE));
    mmio_read(RD_SIZE, rdata);
    chk.compare("RD_SIZE", rdata, 32'(load1_size));
    mmio_write(GO, 32'd1);
    mmio_read(STATUS, rdata);
    chk.compare("STATUS loading", rdata, 32'h1);
    // Register writes and GO are dropped mid-load
    mmio_write(RD_SIZE, 32'd999);
    mmio_write(GO, 32'd1);
    mmio_read(RD_SIZE, rdata);
    chk.compare("RD_SIZE while loading", rdata, 32'(load1_size));
    wait_done();
    mmio_read(STATUS, rdata);
    chk.compare("STATUS done", rdata, 32'h2);
    chk.compare("rd_go pulses", 32'(go_count), 32'd1);
    // DMA request fields stay held after the go pulse
    chk.compare("dma rd_addr", dma_req.rd_addr, 32'(LOAD1_BASE));
    chk.compare("dma rd_size", dma_req.rd_size, 32'(load1_size));
    finish_test("mmio");

    check_counts(load1_inst, load1_const, load1_tri);
    read_words(load1_inst, load1_const);
    finish_test("words");

    read_triangles(load1_tri + 3);
    finish_test("triangles");

    stream_triangles(40);
    finish_test("tri_stream");

    // Second load appends, then hits the bad header
    mmio_write(RD_ADDR, 32'(LOAD2_BASE));
    mmio_write(RD_SIZE, 32'(load2_size));
    mmio_write(GO, 32'd1);
    wait_done();
    mmio_read(STATUS, rdata);
    chk.compare("STATUS error", rdata, 32'h6);
    chk.compare("rd_go pulses", 32'(go_count), 32'd2);
    chk.compare("dma rd_addr", dma_req.rd_addr, 32'(LOAD2_BASE));
    chk.compare("dma rd_size", dma_req.rd_size, 32'(load2_size));
    check_counts(inst_words, const_words, tri_total);
    read_words(inst_words, const_words);
    read_triangles(tri_total + 3);
    finish_test("reload");

    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             tests, failed, chk.checks, chk.errors);
    if (chk.errors == 0 && failed == 0)
      $display("sim passed");
    else
      $display("sim failed");
    $finish;
  end

endmodule
